// ==== bus_glue.f ====
+incdir+tb
hdl/bus_glue_pkg.sv
hdl/machine_config.sv
hdl/bus_slot_timer.sv
hdl/address_decoder.sv
hdl/bus_error_timer.sv
hdl/irq_encoder.sv
hdl/bus_glue_top.sv
tb/bus_glue_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = bus_glue_tb
FILELIST  = bus_glue.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS      = NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, a missing pass line makes grep and so make fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/bus_glue_model.svh ====
/* reference model of the bus glue unit, included inside the testbench module.
   pure functions over the model state that the testbench keeps. */
`ifndef BUS_GLUE_MODEL_SVH
`define BUS_GLUE_MODEL_SVH

// configuration word to the model flags
function automatic sys_cfg_t cfg_flags(input logic [15:0] w);
	sys_cfg_t c;
	c.mem      = w[CFG_MEM_LSB +: 3];
	c.blitter  = w[CFG_BLITTER];
	c.ste      = w[CFG_STE] | w[CFG_MSTE];
	c.mste     = w[CFG_MSTE];
	c.steroids = w[CFG_STE] & w[CFG_MSTE];
	c.ethernec = w[CFG_ETHERNEC];
	c.fast_cpu = (w[CFG_MSTE] & w[CFG_16MHZ]) | c.steroids;
	return c;
endfunction

// byte address a inside lo .. lo + size - 1
function automatic logic in_span(input logic [23:0] a, input logic [23:0] lo,
	input logic [31:0] size);
	return ({8'h00, a} >= {8'h00, lo}) && ({8'h00, a} < ({8'h00, lo} + size));
endfunction

function automatic logic cpu_owns_slot(input sys_cfg_t c, input logic [1:0] slot);
	return (slot == 2'd1) || (c.fast_cpu && (slot == 2'd3));
endfunction

// i/o map of the ff page plus the rom port
function automatic io_sel_t io_selects(input sys_cfg_t c, input cpu_req_t q, input logic cyc);
	io_sel_t     s;
	logic [23:0] a;
	logic        io;
	logic        mste_only;
	logic        port;
	a         = {q.addr, 1'b0};
	io        = cyc && q.as && (a[23:16] == 8'hff);
	mste_only = c.mste && !c.steroids;
	port      = c.ethernec && cyc && q.as && q.rw && in_span(a, 24'hfa0000, 32'h20000);
	s.mmu     = io && in_span(a, 24'hff8000, 14);
	s.vreg    = io && (in_span(a, 24'hff8200, 14) || in_span(a, 24'hff8240, 64) ||
		(c.ste && in_span(a, 24'hff820e, 2)));
	// odd byte lane only
	s.mfp     = io && !q.lds_n && in_span(a, 24'hfffa00, 64);
	s.acia    = io && in_span(a, 24'hfffc00, 512);
	s.psg     = io && in_span(a, 24'hff8800, 256);
	s.dma     = io && ((in_span(a, 24'hff8604, 4) && !q.uds_n && !q.lds_n) ||
		in_span(a, 24'hff8608, 6) || (c.ste && in_span(a, 24'hff860e, 2)));
	s.blitter   = io && (c.blitter || c.ste) && in_span(a, 24'hff8a00, 64);
	s.ste_joy   = io && c.ste && in_span(a, 24'hff9200, 64);
	s.ste_snd   = io && c.ste && in_span(a, 24'hff8900, 64);
	s.mste_ctrl = io && mste_only && in_span(a, 24'hff8e20, 2);
	s.vme       = io && mste_only && in_span(a, 24'hff8e00, 16);
	// fb half is rom[1]
	s.rom       = {port && a[16], port && !a[16]};
	return s;
endfunction

// ram grows with the memory code, rom answers reads only
function automatic logic mem_hit(input sys_cfg_t c, input cpu_req_t q);
	logic [23:0] a;
	logic        low;
	logic        ram;
	logic        rom;
	a   = {q.addr, 1'b0};
	low = (a < 24'h000008);
	ram = !low && ((a < 24'h400000) ||
		(((c.mem == MEM_8M) || (c.mem == MEM_14M)) && in_span(a, 24'h400000, 32'h400000)) ||
		((c.mem == MEM_14M) && in_span(a, 24'h800000, 32'h600000)) ||
		(c.steroids && in_span(a, 24'he80000, 32'h80000)));
	rom = low || in_span(a, 24'he00000, 32'h40000) || in_span(a, 24'hfc0000, 32'h30000) ||
		(!c.ethernec && in_span(a, 24'hfa0000, 32'h20000));
	return ram || (q.rw && rom);
endfunction

// saturating dtack timeout, only berr_clr leaves the top
function automatic logic [3:0] next_timeout(input logic [3:0] t, input logic clr,
	input logic cyc, input logic cend, input logic ok);
	if (clr) begin
		return 4'd0;
	end else if ((t == TIMEOUT_MAX) || !cyc) begin
		return t;
	end else if (ok) begin
		return 4'd0;
	end
	return cend ? t + 4'd1 : t;
endfunction

function automatic logic [2:0] priority_ipl(input logic mfp, input logic [1:0] pend);
	if (mfp) begin
		return IPL_MFP;
	end else if (pend[1]) begin
		return IPL_VBI;
	end
	return pend[0] ? IPL_HBI : IPL_IDLE;
endfunction

function automatic logic [7:0] autovector_for(input logic vbi, input logic hbi);
	return vbi ? VEC_VBI : (hbi ? VEC_HBI : 8'h00);
endfunction

`endif

// ==== tb/bus_glue_tb.sv ====
/* testbench of the bus glue unit. random stimulus from a fixed seed runs
   through slot, decode, timeout and interrupt phases, checked every clock. */
`timescale 1ns/1ns
`default_nettype none

module bus_glue_tb
	import bus_glue_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	localparam int MODE_IDLE    = 0;
	localparam int MODE_DECODE  = 1;
	localparam int MODE_TIMEOUT = 2;
	localparam int MODE_IRQ     = 3;
	localparam int MODE_ACK     = 4;
	localparam int N_SLOTS      = 40;
	localparam int N_DECODE     = 4000;
	localparam int N_TIMEOUT    = 2000;
	localparam int N_IRQ        = 2000;
	localparam int N_ACK        = 2000;
	localparam int N_TOTAL      = 2 * N_SLOTS + N_DECODE + 2 * N_TIMEOUT + N_IRQ + N_ACK;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TOTAL + 200) * CLK_PERIOD;
	// mega ste at 16 MHz
	localparam logic [15:0] FAST_CFG = 16'(1 << CFG_MSTE) | 16'(1 << CFG_16MHZ);

	logic             clk_32;
	logic             berr_reset;
	logic             cfg_wr;
	logic [CFG_W-1:0] cfg_data;
	cpu_req_t         req;
	logic             br;
	logic             berr_clr;
	logic             vsync;
	logic             hsync;
	logic             mfp_irq;
	io_sel_t          sel;
	logic             mem_access;
	logic             dtack;
	logic             berr;
	logic [7:0]       berr_count;
	logic [2:0]       ipl;
	logic [7:0]       auto_vector;
	logic             mfp_iack;
	logic             cpu_cycle;

	// model state
	logic [15:0] m_cfg_word;
	logic [1:0]  m_phase;
	logic [1:0]  m_slot;
	logic [3:0]  m_timeout;
	logic        m_berr_d;
	logic [7:0]  m_berr_count;
	logic [1:0]  m_sync1;
	logic [1:0]  m_sync2;
	logic [1:0]  m_sync3;
	logic [1:0]  m_pend;
	logic [2:0]  m_ipl;
	logic        m_mfp_iack;

	// expected combinational values of the current cycle
	sys_cfg_t    e_cfg;
	logic        e_cpu_cycle;
	logic        e_cycle_end;
	io_sel_t     e_sel;
	logic        e_mem;
	logic        e_dtack;
	logic        e_iack;
	logic        e_ack_vbi;
	logic        e_ack_hbi;
	logic [7:0]  e_vector;

	integer      seed;
	int          errors;
	int          cycle;
	int          n_berr_rise;
	int          n_ack_vbi;
	int          n_ack_hbi;
	int          n_ack_mfp;

	`include "bus_glue_model.svh"

	bus_glue_top u_dut (
		.clk_32      (clk_32),
		.berr_reset  (berr_reset),
		.cfg_wr      (cfg_wr),
		.cfg_data    (cfg_data),
		.req         (req),
		.br          (br),
		.berr_clr    (berr_clr),
		.vsync       (vsync),
		.hsync       (hsync),
		.mfp_irq     (mfp_irq),
		.sel         (sel),
		.mem_access  (mem_access),
		.dtack       (dtack),
		.berr        (berr),
		.berr_count  (berr_count),
		.ipl         (ipl),
		.auto_vector (auto_vector),
		.mfp_iack    (mfp_iack),
		.cpu_cycle   (cpu_cycle)
	);

	initial clk_32 = 1'b0;
	always #(CLK_PERIOD / 2) clk_32 = ~clk_32;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("MISMATCH %s expected %h actual %h at cycle %0d", name, exp, act, cycle);
	endtask

	// address near one of the windows, offset -256 .. 255 to hit the edges
	function automatic logic [23:0] pick_addr();
		logic [31:0] r;
		logic [31:0] s;
		logic [23:0] base;
		r = $random(seed);
		s = $random(seed);
		case (r[13:9])
			5'd0:    base = 24'hff8000;
			5'd1:    base = 24'hff8200;
			5'd2:    base = 24'hff8240;
			5'd3:    base = 24'hff8600;
			5'd4:    base = 24'hff8800;
			5'd5:    base = 24'hff8900;
			5'd6:    base = 24'hff8a00;
			5'd7:    base = 24'hff8e00;
			5'd8:    base = 24'hff8e20;
			5'd9:    base = 24'hff9200;
			5'd10:   base = 24'hfffa00;
			5'd11:   base = 24'hfffc00;
			5'd12:   base = 24'hfffe00;
			5'd13:   base = 24'hfa0000;
			5'd14:   base = 24'hfc0000;
			5'd15:   base = 24'hff0000;
			5'd16:   base = 24'he40000;
			5'd17:   base = 24'he80000;
			5'd18:   base = 24'h000100;
			5'd19:   base = 24'h400000;
			5'd20:   base = 24'h800000;
			5'd21:   base = 24'hc00000;
			5'd22:   base = 24'he00000;
			default: base = s[23:0];
		endcase
		return base + {{15{r[8]}}, r[8:0]};
	endfunction

	// sampled half a clock after the drive, before the next edge
	task automatic compare_outputs();
		e_cfg       = cfg_flags(m_cfg_word);
		e_cpu_cycle = cpu_owns_slot(e_cfg, m_slot);
		e_cycle_end = (m_phase == 2'd3);
		e_iack      = e_cpu_cycle && req.as && (req.fc == FC_IACK);
		e_ack_vbi   = e_iack && (req.addr[3:1] == LVL_VBI);
		e_ack_hbi   = e_iack && (req.addr[3:1] == LVL_HBI);
		e_vector    = autovector_for(e_ack_vbi, e_ack_hbi);
		e_sel       = io_selects(e_cfg, req, e_cpu_cycle);
		e_mem       = mem_hit(e_cfg, req);
		e_dtack     = ((e_mem && e_cpu_cycle && req.as) || (|e_sel) || e_ack_vbi ||
			e_ack_hbi) && !br;
		if (cpu_cycle !== e_cpu_cycle) report_mismatch("cpu_cycle", 32'(e_cpu_cycle),
			32'(cpu_cycle));
		if (sel !== e_sel) report_mismatch("sel", 32'(e_sel), 32'(sel));
		if (mem_access !== e_mem) report_mismatch("mem_access", 32'(e_mem), 32'(mem_access));
		if (dtack !== e_dtack) report_mismatch("dtack", 32'(e_dtack), 32'(dtack));
		if (berr !== (m_timeout == TIMEOUT_MAX)) report_mismatch("berr",
			32'(m_timeout == TIMEOUT_MAX), 32'(berr));
		if (berr_count !== m_berr_count) report_mismatch("berr_count", 32'(m_berr_count),
			32'(berr_count));
		if (ipl !== m_ipl) report_mismatch("ipl", 32'(m_ipl), 32'(ipl));
		if (auto_vector !== e_vector) report_mismatch("auto_vector", 32'(e_vector),
			32'(auto_vector));
		if (mfp_iack !== m_mfp_iack) report_mismatch("mfp_iack", 32'(m_mfp_iack),
			32'(mfp_iack));
	endtask

	// one clock edge of the model, inputs are still the ones just checked
	task automatic advance_model();
		logic [1:0] rise;
		if ((m_timeout == TIMEOUT_MAX) && !m_berr_d) begin
			m_berr_count = m_berr_count + 8'd1;
			n_berr_rise++;
		end
		m_berr_d   = (m_timeout == TIMEOUT_MAX);
		m_timeout  = next_timeout(m_timeout, berr_clr, e_cpu_cycle, e_cycle_end,
			e_dtack || br);
		rise       = m_sync2 & ~m_sync3;
		m_ipl      = priority_ipl(mfp_irq, m_pend);
		// acknowledge beats a new edge
		m_pend     = (m_pend | rise) & ~{e_ack_vbi, e_ack_hbi};
		m_sync3    = m_sync2;
		m_sync2    = m_sync1;
		m_sync1    = {vsync, hsync};
		m_mfp_iack = e_iack && (req.addr[3:1] == LVL_MFP);
		n_ack_vbi  = n_ack_vbi + int'(e_ack_vbi);
		n_ack_hbi  = n_ack_hbi + int'(e_ack_hbi);
		n_ack_mfp  = n_ack_mfp + int'(m_mfp_iack);
		if (m_phase == 2'd3) begin
			m_slot = m_slot + 2'd1;
		end
		m_phase = m_phase + 2'd1;
		if (cfg_wr) begin
			m_cfg_word = cfg_data;
		end
		cycle++;
	endtask

	task automatic drive_inputs(input int mode);
		logic [31:0] r;
		logic [31:0] s;
		logic [23:0] a;
		logic [2:0]  lvl;
		r        = $random(seed);
		s        = $random(seed);
		cfg_wr   = 1'b0;
		cfg_data = s[15:0];
		br       = 1'b0;
		berr_clr = 1'b0;
		case (mode)
			MODE_DECODE: begin
				a         = pick_addr();
				cfg_wr    = (r[3:0] == 4'd0);
				req.addr  = a[23:1];
				req.as    = r[4] | r[5];
				req.rw    = r[6];
				req.uds_n = r[7];
				req.lds_n = r[8];
				req.fc    = r[11:9];
				br        = (r[14:12] == 3'd0);
				berr_clr  = (r[19:15] == 5'd0);
				vsync     = r[20];
				hsync     = r[21];
				mfp_irq   = r[22];
			end
			MODE_TIMEOUT: begin
				// unmapped f0 page, now and then a ram word that answers
				a         = (r[7:0] == 8'd0) ? {8'h01, s[31:16]} : {8'hf0, s[31:16]};
				req.addr  = a[23:1];
				req.as    = 1'b1;
				req.rw    = r[8];
				req.uds_n = 1'b0;
				req.lds_n = 1'b0;
				req.fc    = 3'd5;
				br        = (r[15:9] == 7'd0);
				// cpu takes the exception a few clocks after berr
				berr_clr  = ((m_timeout == TIMEOUT_MAX) && (r[19:16] == 4'd0)) ||
					(r[28:20] == 9'd0);
				vsync     = 1'b0;
				hsync     = 1'b0;
				mfp_irq   = 1'b0;
			end
			MODE_IRQ, MODE_ACK: begin
				if (mode == MODE_ACK) begin
					case (r[3:2])
						2'd0:    lvl = LVL_HBI;
						2'd1:    lvl = LVL_VBI;
						2'd2:    lvl = LVL_MFP;
						default: lvl = r[6:4];
					endcase
					req.as = 1'b1;
					req.fc = (r[1:0] == 2'd0) ? 3'd6 : FC_IACK;
				end else begin
					lvl    = r[6:4];
					req.as = (r[3:0] == 4'd0);
					req.fc = r[9:7];
				end
				req.addr  = {20'hfffff, lvl};
				req.rw    = 1'b1;
				req.uds_n = 1'b0;
				req.lds_n = 1'b0;
				// vsync slow, hsync fast, mfp level rarely moves
				if (r[13:10] == 4'd0) begin
					vsync = !vsync;
				end
				if (r[15:14] == 2'd0) begin
					hsync = !hsync;
				end
				if (r[20:16] == 5'd0) begin
					mfp_irq = !mfp_irq;
				end
			end
			default: begin
				req     = '0;
				vsync   = 1'b0;
				hsync   = 1'b0;
				mfp_irq = 1'b0;
			end
		endcase
	endtask

	task automatic run_mode(input int mode, input int n);
		repeat (n) begin
			@(negedge clk_32);
			compare_outputs();
			@(posedge clk_32);
			advance_model();
			#5;
			drive_inputs(mode);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		seed         = 28170;
		errors       = 0;
		cycle        = 0;
		n_berr_rise  = 0;
		n_ack_vbi    = 0;
		n_ack_hbi    = 0;
		n_ack_mfp    = 0;
		berr_reset   = 1'b1;
		cfg_wr       = 1'b0;
		cfg_data     = '0;
		req          = '0;
		br           = 1'b0;
		berr_clr     = 1'b0;
		vsync        = 1'b0;
		hsync        = 1'b0;
		mfp_irq      = 1'b0;
		m_cfg_word   = '0;
		m_phase      = '0;
		m_slot       = '0;
		m_timeout    = '0;
		m_berr_d     = 1'b0;
		m_berr_count = '0;
		m_sync1      = '0;
		m_sync2      = '0;
		m_sync3      = '0;
		m_pend       = '0;
		m_ipl        = IPL_IDLE;
		m_mfp_iack   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_32);
		#5;
		berr_reset = 1'b0;

		// slot 1 only, then slots 1 and 3 at 16 MHz
		run_mode(MODE_IDLE, N_SLOTS);
		cfg_wr   = 1'b1;
		cfg_data = FAST_CFG;
		run_mode(MODE_IDLE, N_SLOTS);
		run_mode(MODE_DECODE, N_DECODE);
		cfg_wr   = 1'b1;
		cfg_data = 16'h0000;
		run_mode(MODE_TIMEOUT, N_TIMEOUT);
		cfg_wr   = 1'b1;
		cfg_data = FAST_CFG;
		run_mode(MODE_TIMEOUT, N_TIMEOUT);
		run_mode(MODE_IRQ, N_IRQ);
		run_mode(MODE_ACK, N_ACK);

		if (n_berr_rise < 2) begin
			errors++;
			$display("bus error rose only %0d times, timeout not exercised", n_berr_rise);
		end
		if ((n_ack_vbi == 0) || (n_ack_hbi == 0) || (n_ack_mfp == 0)) begin
			errors++;
			$display("not every acknowledge level was issued during a cpu slot");
		end
		$display("cycles %0d, bus errors %0d, errors %0d", cycle, n_berr_rise, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/bus_glue_top.sv ====
/* top level of the bus glue unit. wires the configuration register,
   slot timer, address decoder, dtack timeout and interrupt encoder. */
`timescale 1ns/1ns
`default_nettype none

module bus_glue_top
	import bus_glue_pkg::*;
(
	input  wire logic             clk_32,
	input  wire logic             berr_reset,
	input  wire logic             cfg_wr,
	input  wire logic [CFG_W-1:0] cfg_data,
	input  cpu_req_t              req,
	input  wire logic             br,
	input  wire logic             berr_clr,
	input  wire logic             vsync,
	input  wire logic             hsync,
	input  wire logic             mfp_irq,
	output io_sel_t               sel,
	output logic                  mem_access,
	output logic                  dtack,
	output logic                  berr,
	output logic      [7:0]       berr_count,
	output logic      [2:0]       ipl,
	output logic      [7:0]       auto_vector,
	output logic                  mfp_iack,
	output logic                  cpu_cycle
);

	sys_cfg_t cfg;
	logic     cycle_end;
	logic     auto_iack;

	machine_config u_config (
		.clk_32     (clk_32),
		.berr_reset (berr_reset),
		.cfg_wr     (cfg_wr),
		.cfg_data   (cfg_data),
		.cfg        (cfg)
	);

	bus_slot_timer u_slot_timer (
		.clk_32     (clk_32),
		.berr_reset (berr_reset),
		.cfg        (cfg),
		.cpu_cycle  (cpu_cycle),
		.cycle_end  (cycle_end)
	);

	// autovector acknowledges are answered with dtack from the decoder
	address_decoder u_decoder (
		.cfg        (cfg),
		.req        (req),
		.cpu_cycle  (cpu_cycle),
		.br         (br),
		.auto_iack  (auto_iack),
		.sel        (sel),
		.mem_access (mem_access),
		.dtack      (dtack)
	);

	bus_error_timer u_berr_timer (
		.clk_32     (clk_32),
		.berr_reset (berr_reset),
		.cpu_cycle  (cpu_cycle),
		.cycle_end  (cycle_end),
		.dtack      (dtack),
		.br         (br),
		.berr_clr   (berr_clr),
		.berr       (berr),
		.berr_count (berr_count)
	);

	irq_encoder u_irq (
		.clk_32      (clk_32),
		.berr_reset  (berr_reset),
		.req         (req),
		.cpu_cycle   (cpu_cycle),
		.vsync       (vsync),
		.hsync       (hsync),
		.mfp_irq     (mfp_irq),
		.ipl         (ipl),
		.auto_vector (auto_vector),
		.auto_iack   (auto_iack),
		.mfp_iack    (mfp_iack)
	);

endmodule

`default_nettype wire

// ==== hdl/irq_encoder.sv ====
/* st interrupt logic. latches vbi and hbi on sync edges, encodes the
   priority onto ipl and decodes acknowledge cycles into autovectors. */
`timescale 1ns/1ns
`default_nettype none

module irq_encoder
	import bus_glue_pkg::*;
(
	input  wire logic       clk_32,
	input  wire logic       berr_reset,
	input  cpu_req_t        req,
	input  wire logic       cpu_cycle,
	input  wire logic       vsync,
	input  wire logic       hsync,
	input  wire logic       mfp_irq,
	output logic      [2:0] ipl,
	output logic      [7:0] auto_vector,
	output logic            auto_iack,
	output logic            mfp_iack
);

	// bit 1 is vsync/vbi, bit 0 is hsync/hbi
	logic [2:0][1:0] sync_sr;
	logic      [1:0] sync_rise;
	logic      [1:0] pend;
	logic      [1:0] ack;
	logic            iack;
	logic      [2:0] level;

	// interrupt acknowledge cycle, level comes on address bits 3..1
	assign iack  = cpu_cycle && req.as && (req.fc == FC_IACK);
	assign level = req.addr[3:1];
	assign ack   = {iack && (level == LVL_VBI), iack && (level == LVL_HBI)};

	// two sync flops plus one more for the edge
	assign sync_rise = sync_sr[1] & ~sync_sr[2];

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			sync_sr <= '0;
			pend    <= 2'b00;
		end else begin
			sync_sr <= {sync_sr[1:0], {vsync, hsync}};
			// acknowledge wins over a new edge
			pend    <= (pend | sync_rise) & ~ack;
		end
	end

	// ipl bit 0 is tied high on the st, so only levels 6, 4 and 2 show up
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			ipl      <= IPL_IDLE;
			mfp_iack <= 1'b0;
		end else begin
			if (mfp_irq) begin
				ipl <= IPL_MFP;
			end else if (pend[1]) begin
				ipl <= IPL_VBI;
			end else if (pend[0]) begin
				ipl <= IPL_HBI;
			end else begin
				ipl <= IPL_IDLE;
			end
			// registered so the mfp sees a clean edge
			mfp_iack <= iack && (level == LVL_MFP);
		end
	end

	// vbi and hbi are served with vectors from here, not by the mfp
	assign auto_iack   = |ack;
	assign auto_vector = ack[1] ? VEC_VBI : (ack[0] ? VEC_HBI : 8'h00);

endmodule

`default_nettype wire

// ==== hdl/bus_error_timer.sv ====
/* dtack timeout of the cpu bus. raises berr when a cpu cycle sees no dtack
   for TIMEOUT_MAX cycle ends, and counts bus errors for debugging. */
`timescale 1ns/1ns
`default_nettype none

module bus_error_timer
	import bus_glue_pkg::*;
(
	input  wire logic       clk_32,
	input  wire logic       berr_reset,
	input  wire logic       cpu_cycle,
	input  wire logic       cycle_end,
	input  wire logic       dtack,
	input  wire logic       br,
	input  wire logic       berr_clr,
	output logic            berr,
	output logic      [7:0] berr_count
);

	logic [3:0] timeout;
	logic       berr_d;
	logic       bus_ok;

	// another bus master owning the bus is no error either
	assign bus_ok = dtack || br;

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			timeout <= 4'd0;
		end else if (berr_clr) begin
			// cpu has taken the exception
			timeout <= 4'd0;
		end else if (cpu_cycle && (timeout != TIMEOUT_MAX)) begin
			if (bus_ok) begin
				timeout <= 4'd0;
			end else if (cycle_end) begin
				timeout <= timeout + 4'd1;
			end
		end
	end

	assign berr = (timeout == TIMEOUT_MAX);

	// one count per rising edge of berr, wraps at 8 bits
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			berr_d     <= 1'b0;
			berr_count <= 8'd0;
		end else begin
			berr_d <= berr;
			if (berr && !berr_d) begin
				berr_count <= berr_count + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/address_decoder.sv ====
/* memory map of the st bus. turns the latched cpu request into
   peripheral selects, a memory access flag and dtack, all combinational. */
`timescale 1ns/1ns
`default_nettype none

module address_decoder
	import bus_glue_pkg::*;
(
	input  sys_cfg_t   cfg,
	input  cpu_req_t   req,
	input  wire logic  cpu_cycle,
	input  wire logic  br,
	input  wire logic  auto_iack,
	output io_sel_t    sel,
	output logic       mem_access,
	output logic       dtack
);

	logic io_cyc;
	logic rom_all;
	logic word_acc;
	logic low_rom;
	logic ram;
	logic rom;

	// true when the byte address lies in the window base .. base + 2**aw - 1
	function automatic logic in_win(input logic [23:1] a, input logic [23:0] base,
		input int aw);
		logic [23:0] mask;
		mask = 24'hffffff << aw;
		return ({a, 1'b0} & mask) == (base & mask);
	endfunction

	// all io lives in the top 64k page
	assign io_cyc   = cpu_cycle && req.as && in_win(req.addr, IO_BASE, IO_AW);
	assign word_acc = !req.uds_n && !req.lds_n;

	// rom port at fa0000 - fbffff, reads only, used by the ethernet card
	assign rom_all = cfg.ethernec && cpu_cycle && req.as && req.rw &&
		in_win(req.addr, CART_BASE, CART_AW);

	always_comb begin
		sel = '0;
		// ff8000 - ff800d
		sel.mmu = io_cyc && (in_win(req.addr, MMU_BASE, 3) ||
			in_win(req.addr, MMU_BASE + 24'h8, 2) ||
			in_win(req.addr, MMU_BASE + 24'hc, 1));
		// ff8200 - ff820d, ff820e on ste, palette ff8240 - ff827f
		sel.vreg = io_cyc && (in_win(req.addr, VREG_BASE, 3) ||
			in_win(req.addr, VREG_BASE + 24'h8, 2) ||
			in_win(req.addr, VREG_BASE + 24'hc, 1) ||
			(cfg.ste && in_win(req.addr, VREG_BASE + 24'he, 1)) ||
			in_win(req.addr, PAL_BASE, PAL_AW));
		// odd byte and word only
		sel.mfp  = io_cyc && !req.lds_n && in_win(req.addr, MFP_BASE, REG64_AW);
		sel.acia = io_cyc && in_win(req.addr, ACIA_BASE, ACIA_AW);
		sel.psg  = io_cyc && in_win(req.addr, PSG_BASE, PSG_AW);
		// ff8604 is word access only, ff860e exists on ste
		sel.dma = io_cyc && ((in_win(req.addr, DMA_BASE, 2) && word_acc) ||
			in_win(req.addr, DMA_BASE + 24'h4, 2) ||
			in_win(req.addr, DMA_BASE + 24'h8, 1) ||
			(cfg.ste && in_win(req.addr, DMA_BASE + 24'ha, 1)));
		// an ste always has a blitter
		sel.blitter = (cfg.blitter || cfg.ste) && io_cyc &&
			in_win(req.addr, BLIT_BASE, REG64_AW);
		sel.ste_joy = cfg.ste && io_cyc && in_win(req.addr, JOY_BASE, REG64_AW);
		sel.ste_snd = cfg.ste && io_cyc && in_win(req.addr, SND_BASE, REG64_AW);
		// steroids has no speed control, it always runs flat out
		sel.mste_ctrl = cfg.mste && !cfg.steroids && io_cyc &&
			in_win(req.addr, MSTE_BASE, MSTE_AW);
		sel.vme = cfg.mste && !cfg.steroids && io_cyc && in_win(req.addr, VME_BASE, VME_AW);
		// address bit 16 picks the rom port half
		sel.rom[1] = rom_all && req.addr[16];
		sel.rom[0] = rom_all && !req.addr[16];
	end

	// first 8 bytes mirror the tos rom
	assign low_rom = in_win(req.addr, RAM_BASE0, LOWROM_AW);

	// 4MB always, more banks with 8MB and 14MB, plus 512k at e80000 on steroids
	assign ram = !low_rom && (in_win(req.addr, RAM_BASE0, RAM_BANK_AW) ||
		(((cfg.mem == MEM_8M) || (cfg.mem == MEM_14M)) &&
			in_win(req.addr, RAM_BASE1, RAM_BANK_AW)) ||
		((cfg.mem == MEM_14M) && (in_win(req.addr, RAM_BASE2, RAM_BANK_AW) ||
			in_win(req.addr, RAM_TOP, RAM_TOP_AW))) ||
		(cfg.steroids && in_win(req.addr, XRAM_BASE, XRAM_AW)));

	// 256k tos at e00000, 192k tos at fc0000, cartridge unless the rom port is in use
	assign rom = low_rom || in_win(req.addr, TOS256_BASE, TOS256_AW) ||
		in_win(req.addr, TOS192_BASE, 17) || in_win(req.addr, TOS192_EXT, 16) ||
		(!cfg.ethernec && in_win(req.addr, CART_BASE, CART_AW));

	// rom writes get no dtack and end in a bus error
	assign mem_access = ram || (req.rw && rom);

	assign dtack = ((mem_access && cpu_cycle && req.as) || (|sel) || auto_iack) && !br;

endmodule

`default_nettype wire

// ==== hdl/bus_slot_timer.sv ====
/* four phase, four slot bus cycle timing on clk_32.
   slot 1 belongs to the cpu, slot 3 too when the fast cpu flag is set. */
`timescale 1ns/1ns
`default_nettype none

module bus_slot_timer
	import bus_glue_pkg::*;
(
	input  wire logic clk_32,
	input  wire logic berr_reset,
	input  sys_cfg_t  cfg,
	output logic      cpu_cycle,
	output logic      cycle_end
);

	logic [1:0] phase;
	logic [1:0] slot;

	// phase counts clocks inside one slot, slot steps at the last phase
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			phase <= 2'd0;
			slot  <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
			if (cycle_end) begin
				slot <= slot + 2'd1;
			end
		end
	end

	assign cycle_end = (phase == 2'(PHASES - 1));

	// slots 0 and 2 are video, 1 is cpu, 3 is the optional second cpu slot
	assign cpu_cycle = (slot == 2'd1) || (cfg.fast_cpu && (slot == 2'd3));

endmodule

`default_nettype wire

// ==== hdl/machine_config.sv ====
/* machine configuration register, loaded by a strobe from the io controller.
   derives the model flags used by the slot timer and the address decoder. */
`timescale 1ns/1ns
`default_nettype none

module machine_config
	import bus_glue_pkg::*;
(
	input  wire logic             clk_32,
	input  wire logic             berr_reset,
	input  wire logic             cfg_wr,
	input  wire logic [CFG_W-1:0] cfg_data,
	output sys_cfg_t              cfg
);

	logic [CFG_W-1:0] cfg_q;

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			cfg_q <= '0;
		end else if (cfg_wr) begin
			cfg_q <= cfg_data;
		end
	end

	always_comb begin
		cfg.mem      = cfg_q[CFG_MEM_LSB +: 3];
		cfg.blitter  = cfg_q[CFG_BLITTER];
		// a mega ste is an ste too
		cfg.ste      = cfg_q[CFG_STE] || cfg_q[CFG_MSTE];
		cfg.mste     = cfg_q[CFG_MSTE];
		// both model bits set selects the steroids machine
		cfg.steroids = cfg_q[CFG_STE] && cfg_q[CFG_MSTE];
		cfg.ethernec = cfg_q[CFG_ETHERNEC];
		// steroids always runs at full speed
		cfg.fast_cpu = (cfg_q[CFG_MSTE] && cfg_q[CFG_16MHZ]) || cfg.steroids;
	end

endmodule

`default_nettype wire

// ==== hdl/bus_glue_pkg.sv ====
/* shared types and constants of the st bus glue unit.
   imported by every rtl module and by the testbench. */
`default_nettype none

package bus_glue_pkg;

	// one latched cpu bus request, strobes are active low
	typedef struct packed {
		logic [23:1] addr;
		logic        as;
		logic        rw;
		logic        uds_n;
		logic        lds_n;
		logic [2:0]  fc;
	} cpu_req_t;

	// decoded machine configuration
	typedef struct packed {
		logic [2:0] mem;
		logic       blitter;
		logic       ste;
		logic       mste;
		logic       steroids;
		logic       ethernec;
		logic       fast_cpu;
	} sys_cfg_t;

	// one bit per decoded i/o target
	typedef struct packed {
		logic       mmu;
		logic       vreg;
		logic       mfp;
		logic       acia;
		logic       psg;
		logic       dma;
		logic       blitter;
		logic       ste_joy;
		logic       ste_snd;
		logic       mste_ctrl;
		logic       vme;
		logic [1:0] rom;
	} io_sel_t;

	// configuration word layout
	localparam int CFG_W        = 16;
	localparam int CFG_MEM_LSB  = 1;
	localparam int CFG_BLITTER  = 4;
	localparam int CFG_STE      = 5;
	localparam int CFG_MSTE     = 6;
	localparam int CFG_ETHERNEC = 7;
	localparam int CFG_16MHZ    = 8;

	// memory size codes
	localparam logic [2:0] MEM_512K = 3'd0;
	localparam logic [2:0] MEM_1M   = 3'd1;
	localparam logic [2:0] MEM_2M   = 3'd2;
	localparam logic [2:0] MEM_4M   = 3'd3;
	localparam logic [2:0] MEM_8M   = 3'd4;
	localparam logic [2:0] MEM_14M  = 3'd5;

	// i/o windows, base and number of address bits inside the window
	localparam logic [23:0] IO_BASE   = 24'hff0000;
	localparam int          IO_AW     = 16;
	localparam logic [23:0] MMU_BASE  = 24'hff8000;
	localparam logic [23:0] VREG_BASE = 24'hff8200;
	localparam logic [23:0] PAL_BASE  = 24'hff8240;
	localparam int          PAL_AW    = 6;
	localparam logic [23:0] DMA_BASE  = 24'hff8604;
	localparam logic [23:0] PSG_BASE  = 24'hff8800;
	localparam int          PSG_AW    = 8;
	localparam logic [23:0] SND_BASE  = 24'hff8900;
	localparam logic [23:0] BLIT_BASE = 24'hff8a00;
	localparam logic [23:0] VME_BASE  = 24'hff8e00;
	localparam int          VME_AW    = 4;
	localparam logic [23:0] MSTE_BASE = 24'hff8e20;
	localparam int          MSTE_AW   = 1;
	localparam logic [23:0] JOY_BASE  = 24'hff9200;
	localparam logic [23:0] MFP_BASE  = 24'hfffa00;
	localparam logic [23:0] ACIA_BASE = 24'hfffc00;
	localparam int          ACIA_AW   = 9;
	// mfp, dma sound, blitter and joystick all span 64 bytes
	localparam int          REG64_AW  = 6;

	// ram, tos and cartridge regions
	localparam logic [23:0] RAM_BASE0   = 24'h000000;
	localparam logic [23:0] RAM_BASE1   = 24'h400000;
	localparam logic [23:0] RAM_BASE2   = 24'h800000;
	localparam int          RAM_BANK_AW = 22;
	localparam logic [23:0] RAM_TOP     = 24'hc00000;
	localparam int          RAM_TOP_AW  = 21;
	localparam logic [23:0] XRAM_BASE   = 24'he80000;
	localparam int          XRAM_AW     = 19;
	localparam int          LOWROM_AW   = 3;
	localparam logic [23:0] TOS256_BASE = 24'he00000;
	localparam int          TOS256_AW   = 18;
	localparam logic [23:0] TOS192_BASE = 24'hfc0000;
	localparam logic [23:0] TOS192_EXT  = 24'hfe0000;
	localparam logic [23:0] CART_BASE   = 24'hfa0000;
	localparam int          CART_AW     = 17;

	localparam logic [3:0] TIMEOUT_MAX = 4'd15;
	localparam logic [2:0] FC_IACK     = 3'd7;
	localparam int         PHASES      = 4;

	// interrupt levels, active low ipl codes and autovectors
	localparam logic [2:0] LVL_MFP  = 3'd6;
	localparam logic [2:0] LVL_VBI  = 3'd4;
	localparam logic [2:0] LVL_HBI  = 3'd2;
	localparam logic [2:0] IPL_MFP  = 3'b001;
	localparam logic [2:0] IPL_VBI  = 3'b011;
	localparam logic [2:0] IPL_HBI  = 3'b101;
	localparam logic [2:0] IPL_IDLE = 3'b111;
	localparam logic [7:0] VEC_VBI  = 8'h1c;
	localparam logic [7:0] VEC_HBI  = 8'h1a;

endpackage

`default_nettype wire
